// File: fuse_rom.hex
// one 36 bit fuse word per line, nine hex digits, fuse index 0 first
// entries 5 and 6 are neither all zeros nor all ones
3c1a0f527
0d94e6b18
7b2c5903e
a41f73cd0
16e08a2f9
0a5c31e47
5f00ff7e1
c3b7294a6
28d41e05b
9e6a3c712
4107bd8ec
f25e19634
6ac8047d1
3b91f6e28
d0473ac95
87e2b5104
51cf08a3e
e8346d0f7
2a6b91c58
7fd03e461
b4195a7ec
0c6e2f893
93a74b15d
46f85c20a
cd2091e7b
1b8e4a3f6
68c57d019
f09b3264e
352dc8b70
a7104e9d2
5e8b6f13c
8c43a0e57
214fd9b86
9d6a07c31
47b1e825f
e0c3549da
1f7826e04
b6d50c9a3
6298fb14e
c4a17d580

// File: sim.f
src/fuse_pkg.sv
src/fuse_hip_glue.sv
src/fuse_array.sv
src/fuse_access_timer.sv
src/fuse_pull_fsm.sv
src/fuse_shadow_regs.sv
src/fuse_pull_top.sv
dv/fuse_pull_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary -sv --top-module fuse_pull_tb -f sim.f -o Vfuse_pull_tb
	./obj_dir/Vfuse_pull_tb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/fuse_pull_tb.sv
`timescale 1ns/10ps

module fuse_pull_tb;

	// ------------------------------------------------------------
	// run length
	// ------------------------------------------------------------

	localparam int RESET_CYCLES = 16;
	// two canary reads and every word, plus the cycle that leaves IDLE
	localparam int PULL_CYCLES  = 1 + (fuse_pkg::FUSE_RD_WAIT + 1) * (fuse_pkg::FUSE_WORDS + 2);
	// the automatic pull after reset and one pull in each later test
	localparam int NUM_PULLS    = 5;
	localparam int NUM_TESTS    = 6;
	localparam int READ_CYCLES  = fuse_pkg::FUSE_WORDS + 4;
	// half as much again as the expected run
	localparam int TIMEOUT_CYCLES =
		(3 * (RESET_CYCLES + NUM_PULLS * PULL_CYCLES + NUM_TESTS * READ_CYCLES)) / 2;

	logic                  clk;
	logic                  rst_n;
	logic                  pull_start;
	logic                  fscan_mode;
	logic                  glue_en_strap;
	fuse_pkg::fuse_index_t rd_index;
	fuse_pkg::fuse_word_t  rd_data;
	logic                  pull_done;
	logic                  canary_err;

	// fuse image as the testbench sees it, and the readback order
	fuse_pkg::fuse_word_t  rom_image [fuse_pkg::FUSE_WORDS];
	fuse_pkg::fuse_index_t read_order [fuse_pkg::FUSE_WORDS];
	integer                seed;
	int                    cycle_cnt;
	int                    check_cnt;
	int                    word_errors;
	int                    flag_errors;
	int                    other_errors;

	fuse_pull_top dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.pull_start    (pull_start),
		.fscan_mode    (fscan_mode),
		.glue_en_strap (glue_en_strap),
		.rd_index      (rd_index),
		.rd_data       (rd_data),
		.pull_done     (pull_done),
		.canary_err    (canary_err)
	);

	always #4 clk = ~clk;

	// a hung pull ends the run here
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// compare tasks and expected values
	// ------------------------------------------------------------

	task automatic check_word(input string name, input fuse_pkg::fuse_word_t exp,
			input fuse_pkg::fuse_word_t act);
		check_cnt++;
		if (act !== exp) begin
			word_errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		check_cnt++;
		if (act !== exp) begin
			flag_errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// a shadow word is what the glue rules make of the fuse image
	function automatic fuse_pkg::fuse_word_t expect_word(input int idx, input logic glue_en,
			input logic scan);
		if (glue_en && scan) begin
			return '0;
		end else if (glue_en && idx > int'(fuse_pkg::ROM_MAX_ADDR)) begin
			return fuse_pkg::CANARY_DEFAULT_WORD;
		end
		return rom_image[idx];
	endfunction

	function automatic logic expect_canary_err(input logic glue_en, input logic scan);
		fuse_pkg::fuse_addr_t zero_addr;
		fuse_pkg::fuse_addr_t one_addr;
		fuse_pkg::fuse_word_t zero_ans;
		fuse_pkg::fuse_word_t one_ans;
		zero_addr = fuse_pkg::CANARY_ZERO_ADDR;
		one_addr  = fuse_pkg::CANARY_ONE_ADDR;
		if (glue_en) begin
			// the glue answers both canaries itself and scan forces them to zero
			zero_ans = '0;
			one_ans  = scan ? '0 : '1;
		end else begin
			// bypassed, the array decodes only the low six bits of a canary address
			zero_ans = rom_image[zero_addr[fuse_pkg::FUSE_INDEX_W-1:0]];
			one_ans  = rom_image[one_addr[fuse_pkg::FUSE_INDEX_W-1:0]];
		end
		return (zero_ans != '0) || (one_ans != '1);
	endfunction

	// ------------------------------------------------------------
	// stimulus helpers, all entered and left on a falling edge
	// ------------------------------------------------------------

	// fisher yates over one slice of the readback order
	task automatic shuffle_range(input int lo, input int hi);
		int                    j;
		fuse_pkg::fuse_index_t tmp;
		for (int k = lo; k <= hi; k++) begin
			read_order[k] = fuse_pkg::fuse_index_t'(k);
		end
		for (int k = hi; k > lo; k--) begin
			j = lo + int'({$random(seed)} % (k - lo + 1));
			tmp           = read_order[k];
			read_order[k] = read_order[j];
			read_order[j] = tmp;
		end
	endtask

	task automatic wait_done();
		while (pull_done !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic run_pull();
		pull_start = 1'b1;
		@(negedge clk);
		pull_start = 1'b0;
		// both flags drop on the cycle after the start pulse
		check_flag("pull_done", 1'b0, pull_done);
		check_flag("canary_err", 1'b0, canary_err);
		wait_done();
	endtask

	task automatic check_pull_result(input logic glue_en, input logic scan);
		check_flag("canary_err", expect_canary_err(glue_en, scan), canary_err);
		shuffle_range(0, fuse_pkg::FUSE_WORDS - 1);
		for (int k = 0; k < fuse_pkg::FUSE_WORDS; k++) begin
			rd_index = read_order[k];
			@(negedge clk);
			check_word($sformatf("rd_data[%0d]", read_order[k]),
				expect_word(int'(read_order[k]), glue_en, scan), rd_data);
		end
		// the controller stays in DONE for the whole readback
		check_flag("pull_done", 1'b1, pull_done);
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------

	task automatic test_reset_values();
		// the pull writes the low words first, so those are read under reset
		shuffle_range(0, RESET_CYCLES - 1);
		shuffle_range(RESET_CYCLES, fuse_pkg::FUSE_WORDS - 1);
		for (int k = 0; k < fuse_pkg::FUSE_WORDS; k++) begin
			rd_index = read_order[k];
			@(negedge clk);
			check_flag("pull_done", 1'b0, pull_done);
			check_flag("canary_err", 1'b0, canary_err);
			check_word($sformatf("rd_data[%0d]", read_order[k]), '0, rd_data);
			if (k == RESET_CYCLES - 1) begin
				rst_n = 1'b1;
			end
		end
		// the controller starts its own pull once reset is gone
		wait_done();
	endtask

	task automatic test_strapped_pull(input logic glue_en, input logic scan);
		glue_en_strap = glue_en;
		fscan_mode    = scan;
		run_pull();
		check_pull_result(glue_en, scan);
	endtask

	task automatic test_repeat_pull();
		// the scan bypass pull left the canary error set
		check_flag("canary_err", 1'b1, canary_err);
		test_strapped_pull(1'b1, 1'b0);
	endtask

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		pull_start    = 1'b0;
		fscan_mode    = 1'b0;
		glue_en_strap = 1'b1;
		rd_index      = '0;
		seed          = 56420;
		check_cnt     = 0;
		word_errors   = 0;
		flag_errors   = 0;
		other_errors  = 0;
		$readmemh("fuse_rom.hex", rom_image);
		for (int k = 0; k < fuse_pkg::FUSE_WORDS; k++) begin
			if ($isunknown(rom_image[k])) begin
				other_errors++;
				$display("fuse image entry %0d was not loaded from fuse_rom.hex", k);
			end
		end

		test_reset_values();
		// the automatic pull ran with glue on and scan off
		check_pull_result(1'b1, 1'b0);
		test_strapped_pull(1'b0, 1'b0);
		test_strapped_pull(1'b1, 1'b1);
		test_strapped_pull(1'b0, 1'b1);
		test_repeat_pull();

		$display("checks %0d, word errors %0d, flag errors %0d, other errors %0d",
			check_cnt, word_errors, flag_errors, other_errors);
		if (word_errors + flag_errors + other_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: src/fuse_pull_top.sv
`timescale 1ns/10ps

module fuse_pull_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pull_start,
	input  logic                  fscan_mode,
	input  logic                  glue_en_strap,
	input  fuse_pkg::fuse_index_t rd_index,
	output fuse_pkg::fuse_word_t  rd_data,
	output logic                  pull_done,
	output logic                  canary_err
);

	// ------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------

	// controller side of the glue block
	fuse_pkg::fuse_addr_t  fuse_address;
	fuse_pkg::fuse_word_t  fuse_readdata_out;
	// array side of the glue block
	fuse_pkg::fuse_addr_t  fuse_address_out;
	fuse_pkg::fuse_word_t  fuse_readdata;
	// read timing
	logic                  timer_load;
	logic                  timer_expire;
	// shadow write port
	logic                  shadow_wr_en;
	fuse_pkg::fuse_index_t shadow_wr_index;
	fuse_pkg::fuse_word_t  shadow_wr_data;

	// ------------------------------------------------------------
	// blocks
	// ------------------------------------------------------------

	fuse_pull_fsm u_fsm (
		.clk             (clk),
		.rst_n           (rst_n),
		.pull_start      (pull_start),
		.timer_expire    (timer_expire),
		.fuse_readdata   (fuse_readdata_out),
		.fuse_address    (fuse_address),
		.timer_load      (timer_load),
		.shadow_wr_en    (shadow_wr_en),
		.shadow_wr_index (shadow_wr_index),
		.shadow_wr_data  (shadow_wr_data),
		.pull_done       (pull_done),
		.canary_err      (canary_err)
	);

	fuse_access_timer u_timer (
		.clk          (clk),
		.rst_n        (rst_n),
		.timer_load   (timer_load),
		.timer_expire (timer_expire)
	);

	// straps go straight to the glue, the controller never sees them
	fuse_hip_glue #(
		.ROM_MAX_ADDR (fuse_pkg::ROM_MAX_ADDR)
	) u_glue (
		.fuse_address      (fuse_address),
		.fuse_readdata     (fuse_readdata),
		.fscan_mode        (fscan_mode),
		.glue_en_strap     (glue_en_strap),
		.fuse_address_out  (fuse_address_out),
		.fuse_readdata_out (fuse_readdata_out)
	);

	fuse_array u_array (
		.clk           (clk),
		.rst_n         (rst_n),
		.fuse_address  (fuse_address_out),
		.fuse_readdata (fuse_readdata)
	);

	fuse_shadow_regs u_shadow (
		.clk             (clk),
		.rst_n           (rst_n),
		.shadow_wr_en    (shadow_wr_en),
		.shadow_wr_index (shadow_wr_index),
		.shadow_wr_data  (shadow_wr_data),
		.rd_index        (rd_index),
		.rd_data         (rd_data)
	);

endmodule

// File: src/fuse_shadow_regs.sv
`timescale 1ns/10ps

module fuse_shadow_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  shadow_wr_en,
	input  fuse_pkg::fuse_index_t shadow_wr_index,
	input  fuse_pkg::fuse_word_t  shadow_wr_data,
	input  fuse_pkg::fuse_index_t rd_index,
	output fuse_pkg::fuse_word_t  rd_data
);

	fuse_pkg::fuse_word_t shadow [fuse_pkg::FUSE_WORDS];
	logic                 wr_valid;
	logic                 rd_valid;

	// guard both ports against the unused top of the index range
	assign wr_valid = shadow_wr_en && (int'(shadow_wr_index) < fuse_pkg::FUSE_WORDS);
	assign rd_valid = (int'(rd_index) < fuse_pkg::FUSE_WORDS);

	// ------------------------------------------------------------
	// shadow storage
	// ------------------------------------------------------------

	// every word reads zero until the first pull overwrites it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < fuse_pkg::FUSE_WORDS; i++) begin
				shadow[i] <= '0;
			end
		end else if (wr_valid) begin
			shadow[shadow_wr_index] <= shadow_wr_data;
		end
	end

	// readback follows the index with no added latency
	assign rd_data = rd_valid ? shadow[rd_index] : '0;

endmodule

// File: src/fuse_pull_fsm.sv
`timescale 1ns/10ps

module fuse_pull_fsm (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pull_start,
	input  logic                  timer_expire,
	input  fuse_pkg::fuse_word_t  fuse_readdata,
	output fuse_pkg::fuse_addr_t  fuse_address,
	output logic                  timer_load,
	output logic                  shadow_wr_en,
	output fuse_pkg::fuse_index_t shadow_wr_index,
	output fuse_pkg::fuse_word_t  shadow_wr_data,
	output logic                  pull_done,
	output logic                  canary_err
);

	localparam fuse_pkg::fuse_index_t LAST_WORD = fuse_pkg::fuse_index_t'(fuse_pkg::FUSE_WORDS - 1);

	fuse_pkg::pull_state_t state;
	fuse_pkg::fuse_index_t word_cnt;

	// ------------------------------------------------------------
	// address and shadow write generation
	// ------------------------------------------------------------

	// the address is held for the whole read since it follows the state
	always_comb begin
		case (state)
			fuse_pkg::CANARY0: fuse_address = fuse_pkg::CANARY_ZERO_ADDR;
			fuse_pkg::CANARY1: fuse_address = fuse_pkg::CANARY_ONE_ADDR;
			fuse_pkg::PULL:    fuse_address = fuse_pkg::fuse_addr_t'(word_cnt);
			default:           fuse_address = '0;
		endcase
	end

	// a pulled word is written on the expire cycle itself
	assign shadow_wr_en    = (state == fuse_pkg::PULL) && timer_expire;
	assign shadow_wr_index = word_cnt;
	assign shadow_wr_data  = fuse_readdata;

	// ------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------

	// timer_load is a one cycle strobe issued with every new address
	// so each read takes FUSE_RD_WAIT plus one cycles end to end
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= fuse_pkg::IDLE;
			word_cnt   <= '0;
			timer_load <= 1'b0;
			pull_done  <= 1'b0;
			canary_err <= 1'b0;
		end else begin
			timer_load <= 1'b0;
			case (state)
				// leave on the first cycle after reset, a start pulse changes nothing here
				fuse_pkg::IDLE: begin
					state      <= fuse_pkg::CANARY0;
					timer_load <= 1'b1;
				end
				// the zero canary must come back as all zeros
				fuse_pkg::CANARY0: begin
					if (timer_expire) begin
						if (fuse_readdata != '0) begin
							canary_err <= 1'b1;
						end
						state      <= fuse_pkg::CANARY1;
						timer_load <= 1'b1;
					end
				end
				// the one canary must come back as all ones
				fuse_pkg::CANARY1: begin
					if (timer_expire) begin
						if (fuse_readdata != '1) begin
							canary_err <= 1'b1;
						end
						state      <= fuse_pkg::PULL;
						word_cnt   <= '0;
						timer_load <= 1'b1;
					end
				end
				// walk the word counter through all shadow slots
				fuse_pkg::PULL: begin
					if (timer_expire) begin
						if (word_cnt == LAST_WORD) begin
							state     <= fuse_pkg::DONE;
							pull_done <= 1'b1;
						end else begin
							word_cnt   <= word_cnt + 1'b1;
							timer_load <= 1'b1;
						end
					end
				end
				// a new pull drops both flags on the next cycle
				fuse_pkg::DONE: begin
					if (pull_start) begin
						state      <= fuse_pkg::CANARY0;
						pull_done  <= 1'b0;
						canary_err <= 1'b0;
						timer_load <= 1'b1;
					end
				end
				default: begin
					state <= fuse_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// File: src/fuse_access_timer.sv
`timescale 1ns/10ps

module fuse_access_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic timer_load,
	output logic timer_expire
);

	fuse_pkg::rd_cnt_t rd_cnt;

	// ------------------------------------------------------------
	// access time counter
	// ------------------------------------------------------------

	// a load restarts the count even if one is still running
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_cnt <= '0;
		end else if (timer_load) begin
			rd_cnt <= fuse_pkg::rd_cnt_t'(fuse_pkg::FUSE_RD_WAIT);
		end else if (rd_cnt != '0) begin
			rd_cnt <= rd_cnt - 1'b1;
		end
	end

	// the last count value gives a single cycle pulse
	// which lands FUSE_RD_WAIT cycles after the load
	// an idle counter sits at zero and stays silent
	assign timer_expire = (rd_cnt == fuse_pkg::rd_cnt_t'(1));

endmodule

// File: src/fuse_array.sv
`timescale 1ns/10ps

module fuse_array (
	input  logic                 clk,
	input  logic                 rst_n,
	input  fuse_pkg::fuse_addr_t fuse_address,
	output fuse_pkg::fuse_word_t fuse_readdata
);

	// behavioural model of the blown fuse contents
	fuse_pkg::fuse_word_t  mem [fuse_pkg::FUSE_WORDS];
	fuse_pkg::fuse_index_t word_idx;
	logic                  idx_valid;

	initial begin
		$readmemh("fuse_rom.hex", mem);
	end

	// only the low six address bits select a word
	assign word_idx = fuse_address[fuse_pkg::FUSE_INDEX_W-1:0];

	// indices past the last word have no fuse behind them
	assign idx_valid = (int'(word_idx) < fuse_pkg::FUSE_WORDS);

	// ------------------------------------------------------------
	// registered read port
	// ------------------------------------------------------------

	// the sense data is captured every cycle from whatever address is applied
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fuse_readdata <= '0;
		end else if (idx_valid) begin
			fuse_readdata <= mem[word_idx];
		end else begin
			fuse_readdata <= '0;
		end
	end

endmodule

// File: src/fuse_hip_glue.sv
`timescale 1ns/10ps

module fuse_hip_glue #(
	parameter logic [14:0] ROM_MAX_ADDR = fuse_pkg::ROM_MAX_ADDR
) (
	input  fuse_pkg::fuse_addr_t fuse_address,
	input  fuse_pkg::fuse_word_t fuse_readdata,
	input  logic                 fscan_mode,
	input  logic                 glue_en_strap,
	output fuse_pkg::fuse_addr_t fuse_address_out,
	output fuse_pkg::fuse_word_t fuse_readdata_out
);

	logic                 addr_in_rom;
	logic                 canary_zero_sel;
	logic                 canary_one_sel;
	fuse_pkg::fuse_addr_t fuse_addr_int;
	fuse_pkg::fuse_word_t canary_or_data;
	fuse_pkg::fuse_word_t fuse_data_muxed;
	fuse_pkg::fuse_word_t fuse_readdata_scan;

	// ------------------------------------------------------------
	// address range check
	// ------------------------------------------------------------

	// bit 15 marks the canary space, so such an address is never a rom location
	assign addr_in_rom = ~fuse_address[15] && (fuse_address[14:0] <= ROM_MAX_ADDR);

	// the array must never see an address past its top
	assign fuse_addr_int = addr_in_rom ? fuse_address : '0;

	// ------------------------------------------------------------
	// canary answers and scan masking
	// ------------------------------------------------------------

	assign canary_zero_sel = (fuse_address == fuse_pkg::CANARY_ZERO_ADDR);
	assign canary_one_sel  = (fuse_address == fuse_pkg::CANARY_ONE_ADDR);

	// all ones, all zeros, or the default word for anything else out of range
	assign canary_or_data = canary_one_sel  ? '1 :
				canary_zero_sel ? '0 : fuse_pkg::CANARY_DEFAULT_WORD;

	assign fuse_data_muxed = addr_in_rom ? fuse_readdata : canary_or_data;

	// in scan mode the fuse values must not leak onto the read path
	assign fuse_readdata_scan = fscan_mode ? '0 : fuse_data_muxed;

	// strap low bypasses the whole block in both directions
	assign fuse_address_out  = glue_en_strap ? fuse_addr_int : fuse_address;
	assign fuse_readdata_out = glue_en_strap ? fuse_readdata_scan : fuse_readdata;

endmodule

// File: src/fuse_pkg.sv
package fuse_pkg;

	// ------------------------------------------------------------
	// fuse word and address geometry
	// ------------------------------------------------------------

	// the fuse controller talks to the array with a 16 bit address
	localparam int FUSE_ADDR_W = 16;
	// every fuse word carries 36 bits of payload
	localparam int FUSE_DATA_W = 36;

	typedef logic [FUSE_ADDR_W-1:0] fuse_addr_t;
	typedef logic [FUSE_DATA_W-1:0] fuse_word_t;

	// highest address that the fuse rom actually holds
	localparam logic [14:0] ROM_MAX_ADDR = 15'd31;

	// canary addresses live in the upper half of the address space
	localparam fuse_addr_t CANARY_ZERO_ADDR = 16'h8005;
	localparam fuse_addr_t CANARY_ONE_ADDR  = 16'h8006;

	// answer for any address past the rom top that is not a canary
	localparam fuse_word_t CANARY_DEFAULT_WORD = 36'h8_0000_0000;

	// ------------------------------------------------------------
	// shadow storage and read timing
	// ------------------------------------------------------------

	localparam int FUSE_WORDS   = 40;
	localparam int FUSE_INDEX_W = 6;

	typedef logic [FUSE_INDEX_W-1:0] fuse_index_t;

	// fixed access time of one fuse read, in clock cycles
	localparam int FUSE_RD_WAIT  = 4;
	localparam int FUSE_RD_CNT_W = $clog2(FUSE_RD_WAIT + 1);

	typedef logic [FUSE_RD_CNT_W-1:0] rd_cnt_t;

	// controller states, canary reads first and then the word pulls
	typedef enum logic [2:0] {
		IDLE,
		CANARY0,
		CANARY1,
		PULL,
		DONE
	} pull_state_t;

endpackage
